//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;    // Data or address word
  typedef logic [4:0]      reg_idx_t; // Destination register index
  typedef logic [31:0]     inst_t;    // Raw instruction word

  // addi x0,x0,0
  localparam inst_t INST_NOP = 32'h0000_0013;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLL = 4'd5,
    ALU_SRL = 4'd6,
    ALU_SLT = 4'd7  // Signed compare
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_NONE = 3'd0,
    MEM_LW   = 3'd1,
    MEM_LBU  = 3'd2,
    MEM_SW   = 3'd3,
    MEM_SB   = 3'd4
  } mem_op_e;

  typedef enum logic [1:0] {
    TRAP_NONE           = 2'd0,
    TRAP_LOAD_MISALIGN  = 2'd1,
    TRAP_STORE_MISALIGN = 2'd2
  } trap_cause_e;

endpackage

`default_nettype wire

//--- logic/pipe_reg.sv
`default_nettype none

module pipe_reg #(
  parameter int unsigned      WIDTH     = 32,
  parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
  input  wire              clk,
  input  wire              reset_i,
  input  wire              wen_i,
  input  wire  [WIDTH-1:0] d_i,
  output logic [WIDTH-1:0] q_o
);

  // Reset has priority over the enable
  always_ff @(posedge clk) begin
    if (reset_i) begin
      q_o <= RESET_VAL;
    end else if (wen_i) begin
      q_o <= d_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/alu_exec.sv
`default_nettype none

module alu_exec (
  input  wire rv_pkg::xlen_t   rs1_data_i,
  input  wire rv_pkg::xlen_t   rs2_data_i,
  input  wire rv_pkg::xlen_t   imm_data_i,
  input  wire                  use_imm_i,
  input  wire rv_pkg::alu_op_e alu_op_i,
  output rv_pkg::xlen_t        alu_data_o
);

  import rv_pkg::*;

  xlen_t      op_b;
  logic [4:0] shamt;

  assign op_b  = use_imm_i ? imm_data_i : rs2_data_i;
  assign shamt = op_b[4:0]; // Only low 5 bits shift

  always_comb begin
    case (alu_op_i)
      ALU_ADD: begin
        alu_data_o = rs1_data_i + op_b; // Also forms load/store address
      end
      ALU_SUB: begin
        alu_data_o = rs1_data_i - op_b;
      end
      ALU_AND: begin
        alu_data_o = rs1_data_i & op_b;
      end
      ALU_OR: begin
        alu_data_o = rs1_data_i | op_b;
      end
      ALU_XOR: begin
        alu_data_o = rs1_data_i ^ op_b;
      end
      ALU_SLL: begin
        alu_data_o = rs1_data_i << shamt;
      end
      ALU_SRL: begin
        alu_data_o = rs1_data_i >> shamt;
      end
      ALU_SLT: begin
        alu_data_o = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
      end
      default: begin
        alu_data_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/ex_mem.sv
`default_nettype none

module ex_mem (
  input  wire                   clk,
  input  wire                   reset_i,
  input  wire                   stall_i,
  input  wire                   flush_i,
  input  wire                   valid_i,
  input  wire rv_pkg::xlen_t    inst_addr_i,
  input  wire rv_pkg::inst_t    inst_data_i,
  input  wire rv_pkg::reg_idx_t rd_idx_i,
  input  wire rv_pkg::xlen_t    rs2_data_i,
  input  wire rv_pkg::xlen_t    alu_data_i,
  input  wire rv_pkg::mem_op_e  mem_op_i,
  output logic                  valid_o,
  output rv_pkg::xlen_t         inst_addr_o,
  output rv_pkg::inst_t         inst_data_o,
  output rv_pkg::reg_idx_t      rd_idx_o,
  output rv_pkg::xlen_t         rs2_data_o,
  output rv_pkg::xlen_t         alu_data_o,
  output rv_pkg::mem_op_e       mem_op_o
);

  import rv_pkg::*;

  logic                         reg_wen;
  logic                         reg_rst;
  logic [$bits(mem_op_e)-1:0]   mem_op_q;

  assign reg_wen = ~stall_i;
  assign reg_rst = reset_i | flush_i; // Flush beats stall

  pipe_reg #(.WIDTH(1), .RESET_VAL(1'b0)) u_valid_reg (
    .clk     (clk),
    .reset_i (reg_rst),
    .wen_i   (reg_wen),
    .d_i     (valid_i),
    .q_o     (valid_o)
  );

  pipe_reg #(.WIDTH(XLEN), .RESET_VAL('0)) u_inst_addr_reg (
    .clk     (clk),
    .reset_i (reg_rst),
    .wen_i   (reg_wen),
    .d_i     (inst_addr_i),
    .q_o     (inst_addr_o)
  );

  pipe_reg #(.WIDTH($bits(inst_t)), .RESET_VAL(INST_NOP)) u_inst_data_reg (
    .clk     (clk),
    .reset_i (reg_rst),
    .wen_i   (reg_wen),
    .d_i     (inst_data_i),
    .q_o     (inst_data_o)
  );

  pipe_reg #(.WIDTH($bits(reg_idx_t)), .RESET_VAL('0)) u_rd_idx_reg (
    .clk     (clk),
    .reset_i (reg_rst),
    .wen_i   (reg_wen),
    .d_i     (rd_idx_i),
    .q_o     (rd_idx_o)
  );

  pipe_reg #(.WIDTH(XLEN), .RESET_VAL('0)) u_rs2_data_reg (
    .clk     (clk),
    .reset_i (reg_rst),
    .wen_i   (reg_wen),
    .d_i     (rs2_data_i),
    .q_o     (rs2_data_o)
  );

  pipe_reg #(.WIDTH(XLEN), .RESET_VAL('0)) u_alu_data_reg (
    .clk     (clk),
    .reset_i (reg_rst),
    .wen_i   (reg_wen),
    .d_i     (alu_data_i),
    .q_o     (alu_data_o)
  );

  pipe_reg #(.WIDTH($bits(mem_op_e)), .RESET_VAL(MEM_NONE)) u_mem_op_reg (
    .clk     (clk),
    .reset_i (reg_rst),
    .wen_i   (reg_wen),
    .d_i     (mem_op_i),
    .q_o     (mem_op_q)
  );

  assign mem_op_o = mem_op_e'(mem_op_q);

endmodule

`default_nettype wire

//--- logic/data_mem_stage.sv
`default_nettype none

module data_mem_stage #(
  parameter int unsigned DMEM_WORDS = 64
) (
  input  wire                   clk,
  input  wire                   reset_i,
  input  wire                   stall_i,
  input  wire                   valid_i,
  input  wire rv_pkg::xlen_t    inst_addr_i,
  input  wire rv_pkg::reg_idx_t rd_idx_i,
  input  wire rv_pkg::xlen_t    rs2_data_i,
  input  wire rv_pkg::xlen_t    alu_data_i,
  input  wire rv_pkg::mem_op_e  mem_op_i,
  output logic                  wb_valid_o,
  output rv_pkg::reg_idx_t      wb_rd_o,
  output rv_pkg::xlen_t         wb_data_o,
  output logic                  trap_valid_o,
  output rv_pkg::trap_cause_e   trap_cause_o,
  output rv_pkg::xlen_t         trap_pc_o
);

  import rv_pkg::*;

  localparam int unsigned IDX_W = $clog2(DMEM_WORDS);

  xlen_t            mem [DMEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic [1:0]       byte_off;
  logic             is_word;
  logic             is_store;
  logic             misalign;
  logic             fire;
  xlen_t            rd_word;
  xlen_t            result;

  assign word_idx = IDX_W'((alu_data_i >> 2) % DMEM_WORDS); // Wraps around the array
  assign byte_off = alu_data_i[1:0];
  assign is_word  = (mem_op_i == MEM_LW) || (mem_op_i == MEM_SW);
  assign is_store = (mem_op_i == MEM_SW) || (mem_op_i == MEM_SB);
  assign misalign = is_word && (byte_off != 2'b00);
  assign fire     = valid_i && !stall_i;

  // Async read, sees a store from the previous edge
  assign rd_word = mem[word_idx];

  always_comb begin
    case (mem_op_i)
      MEM_LW:  result = rd_word;
      MEM_LBU: result = {{(XLEN-8){1'b0}}, rd_word[{byte_off, 3'b000} +: 8]};
      default: result = alu_data_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fire && !misalign) begin
      if (mem_op_i == MEM_SW) begin
        mem[word_idx] <= rs2_data_i;
      end else if (mem_op_i == MEM_SB) begin
        mem[word_idx][{byte_off, 3'b000} +: 8] <= rs2_data_i[7:0]; // Single lane
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_valid_o   <= 1'b0;
      trap_valid_o <= 1'b0;
    end else begin
      wb_valid_o   <= fire && !misalign && !is_store && (rd_idx_i != '0);
      trap_valid_o <= fire && misalign;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o   <= rd_idx_i;
    wb_data_o <= result;
    trap_pc_o <= inst_addr_i;
    if (!misalign) begin
      trap_cause_o <= TRAP_NONE;
    end else if (is_store) begin
      trap_cause_o <= TRAP_STORE_MISALIGN;
    end else begin
      trap_cause_o <= TRAP_LOAD_MISALIGN;
    end
  end

endmodule

`default_nettype wire

//--- logic/ex_mem_sub.sv
`default_nettype none

module ex_mem_sub #(
  parameter int unsigned DMEM_WORDS = 64
) (
  input  wire                   clk,
  input  wire                   reset_i,
  input  wire                   stall_i,
  input  wire                   flush_i,
  input  wire                   valid_i,
  input  wire rv_pkg::xlen_t    inst_addr_i,
  input  wire rv_pkg::inst_t    inst_data_i,
  input  wire rv_pkg::xlen_t    rs1_data_i,
  input  wire rv_pkg::xlen_t    rs2_data_i,
  input  wire rv_pkg::xlen_t    imm_data_i,
  input  wire                   use_imm_i,
  input  wire rv_pkg::reg_idx_t rd_idx_i,
  input  wire rv_pkg::alu_op_e  alu_op_i,
  input  wire rv_pkg::mem_op_e  mem_op_i,
  output logic                  wb_valid_o,
  output rv_pkg::reg_idx_t      wb_rd_o,
  output rv_pkg::xlen_t         wb_data_o,
  output logic                  trap_valid_o,
  output rv_pkg::trap_cause_e   trap_cause_o,
  output rv_pkg::xlen_t         trap_pc_o
);

  import rv_pkg::*;

  xlen_t    alu_data;
  logic     valid_q;
  xlen_t    inst_addr_q;
  reg_idx_t rd_idx_q;
  xlen_t    rs2_data_q;
  xlen_t    alu_data_q;
  mem_op_e  mem_op_q;

  alu_exec u_alu_exec (
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .imm_data_i (imm_data_i),
    .use_imm_i  (use_imm_i),
    .alu_op_i   (alu_op_i),
    .alu_data_o (alu_data)
  );

  ex_mem u_ex_mem (
    .clk         (clk),
    .reset_i     (reset_i),
    .stall_i     (stall_i),
    .flush_i     (flush_i),
    .valid_i     (valid_i),
    .inst_addr_i (inst_addr_i),
    .inst_data_i (inst_data_i),
    .rd_idx_i    (rd_idx_i),
    .rs2_data_i  (rs2_data_i),
    .alu_data_i  (alu_data),
    .mem_op_i    (mem_op_i),
    .valid_o     (valid_q),
    .inst_addr_o (inst_addr_q),
    .inst_data_o (),             // No consumer in this slice
    .rd_idx_o    (rd_idx_q),
    .rs2_data_o  (rs2_data_q),
    .alu_data_o  (alu_data_q),
    .mem_op_o    (mem_op_q)
  );

  data_mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_data_mem_stage (
    .clk          (clk),
    .reset_i      (reset_i),
    .stall_i      (stall_i),
    .valid_i      (valid_q),
    .inst_addr_i  (inst_addr_q),
    .rd_idx_i     (rd_idx_q),
    .rs2_data_i   (rs2_data_q),
    .alu_data_i   (alu_data_q),
    .mem_op_i     (mem_op_q),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o),
    .trap_valid_o (trap_valid_o),
    .trap_cause_o (trap_cause_o),
    .trap_pc_o    (trap_pc_o)
  );

endmodule

`default_nettype wire

//--- tests/ex_mem_sub_assert.sv
`default_nettype none

module ex_mem_sub_assert (
  input wire                   clk,
  input wire                   reset_i,
  input wire                   stall_i,
  input wire                   flush_i,
  input wire                   valid_i,
  input wire rv_pkg::xlen_t    rs1_data_i,
  input wire rv_pkg::xlen_t    rs2_data_i,
  input wire rv_pkg::xlen_t    imm_data_i,
  input wire                   use_imm_i,
  input wire rv_pkg::reg_idx_t rd_idx_i,
  input wire rv_pkg::alu_op_e  alu_op_i,
  input wire rv_pkg::mem_op_e  mem_op_i,
  input wire                   wb_valid_o,
  input wire rv_pkg::reg_idx_t wb_rd_o,
  input wire rv_pkg::xlen_t    wb_data_o,
  input wire                   trap_valid_o
);

  import rv_pkg::*;

  int unsigned fail_cnt = 0; // Failed assertions
  xlen_t       alu_expect;
  logic        alu_issue;
  logic        advance;

  function automatic xlen_t alu_ref(input alu_op_e op, input xlen_t a, input xlen_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  assign alu_expect = alu_ref(alu_op_i, rs1_data_i, use_imm_i ? imm_data_i : rs2_data_i);
  assign alu_issue  = valid_i && (mem_op_i == MEM_NONE) && (rd_idx_i != '0) &&
                      !stall_i && !flush_i && !reset_i;
  assign advance    = !stall_i && !reset_i;

  reset_quiet: assert property (@(posedge clk)
    ($past(reset_i) || $past(reset_i, 2)) |-> !wb_valid_o && !trap_valid_o)
    else begin
      $error("write-back or trap raised during or just after reset");
      fail_cnt++;
    end

  alu_result: assert property (@(posedge clk)
    ($past(alu_issue, 2) && $past(advance)) |->
      wb_valid_o && (wb_rd_o == $past(rd_idx_i, 2)) && (wb_data_o == $past(alu_expect, 2)))
    else begin
      $error("ALU write-back missing or wrong two edges after issue");
      fail_cnt++;
    end

  stall_quiet: assert property (@(posedge clk)
    $past(stall_i) |-> !wb_valid_o && !trap_valid_o)
    else begin
      $error("result produced on a stalled edge");
      fail_cnt++;
    end

  flush_kills: assert property (@(posedge clk)
    $past(flush_i, 2) |-> !wb_valid_o && !trap_valid_o)
    else begin
      $error("flushed instruction still produced a result");
      fail_cnt++;
    end

  one_result: assert property (@(posedge clk) !(wb_valid_o && trap_valid_o))
    else begin
      $error("write-back and trap raised together");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- tests/tb_ex_mem_sub.sv
`default_nettype none

module tb_ex_mem_sub;

  import rv_pkg::*;

  localparam int unsigned DMEM_WORDS     = 64;
  localparam int unsigned TIMEOUT_CYCLES = 50;

  logic        clk;
  logic        reset_i;
  logic        stall_i;
  logic        flush_i;
  logic        valid_i;
  xlen_t       inst_addr_i;
  inst_t       inst_data_i;
  xlen_t       rs1_data_i;
  xlen_t       rs2_data_i;
  xlen_t       imm_data_i;
  logic        use_imm_i;
  reg_idx_t    rd_idx_i;
  alu_op_e     alu_op_i;
  mem_op_e     mem_op_i;
  logic        wb_valid_o;
  reg_idx_t    wb_rd_o;
  xlen_t       wb_data_o;
  logic        trap_valid_o;
  trap_cause_e trap_cause_o;
  xlen_t       trap_pc_o;

  xlen_t       shadow [DMEM_WORDS]; // Expected data memory
  logic [1:0]  exp_kind [$];        // 0 ALU, 1 load, 2 load trap, 3 store trap
  reg_idx_t    exp_rd [$];
  xlen_t       exp_data [$];        // Load data or trap pc
  int unsigned err_cnt;
  int unsigned checked;
  xlen_t       pc;

  ex_mem_sub #(.DMEM_WORDS(DMEM_WORDS)) u_ex_mem_sub (.*);

  bind ex_mem_sub ex_mem_sub_assert u_assert (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic check_outputs();
    logic [1:0]  kind;
    reg_idx_t    rd;
    xlen_t       data;
    trap_cause_e cause;
    if (wb_valid_o || trap_valid_o) begin
      if (exp_kind.size() == 0) begin
        err_cnt++;
        $display("ERR %0t: result arrived with no instruction outstanding", $time);
      end else begin
        kind = exp_kind.pop_front();
        rd   = exp_rd.pop_front();
        data = exp_data.pop_front();
        checked++;
        cause = (kind == 2'd2) ? TRAP_LOAD_MISALIGN : TRAP_STORE_MISALIGN;
        if (kind < 2'd2) begin
          if (!wb_valid_o || trap_valid_o || wb_rd_o != rd) begin
            err_cnt++;
            $display("ERR %0t: expected write-back to x%0d, got valid %0b rd x%0d",
                     $time, rd, wb_valid_o, wb_rd_o);
          end else if (kind == 2'd1 && wb_data_o !== data) begin
            err_cnt++;
            $display("ERR %0t: load to x%0d returned %h, expected %h",
                     $time, rd, wb_data_o, data);
          end
        end else if (!trap_valid_o || wb_valid_o || trap_cause_o != cause ||
                     trap_pc_o != data) begin
          err_cnt++;
          $display("ERR %0t: expected trap %0d at pc %h, got valid %0b cause %0d pc %h",
                   $time, cause, data, trap_valid_o, trap_cause_o, trap_pc_o);
        end
      end
    end
  endtask

  // Outputs are checked mid-cycle, inputs change just after the edge
  task automatic step();
    @(negedge clk);
    check_outputs();
    @(posedge clk);
    #1;
  endtask

  task automatic push_expected(input logic [1:0] kind, input reg_idx_t rd, input xlen_t data);
    exp_kind.push_back(kind);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
  endtask

  task automatic send(input alu_op_e aop, input mem_op_e mop, input xlen_t rs1,
                      input xlen_t rs2, input xlen_t imm, input logic sel_imm,
                      input reg_idx_t rd, input logic may_kill);
    int          stalls;
    logic        kill;
    xlen_t       addr;
    int unsigned idx;
    logic [4:0]  lane;
    stalls = ($urandom_range(3) == 0) ? int'($urandom_range(4, 1)) : 0;
    kill   = may_kill && ($urandom_range(7) == 0);
    valid_i     = 1'b1;
    inst_addr_i = pc;
    inst_data_i = $urandom;
    rs1_data_i  = rs1;
    rs2_data_i  = rs2;
    imm_data_i  = imm;
    use_imm_i   = sel_imm;
    rd_idx_i    = rd;
    alu_op_i    = aop;
    mem_op_i    = mop;
    repeat (stalls) begin // Upstream holds the instruction
      stall_i = 1'b1;
      step();
    end
    stall_i = 1'b0;
    flush_i = kill;
    if (!kill) begin
      addr = rs1 + (sel_imm ? imm : rs2);
      idx  = (addr >> 2) % DMEM_WORDS;
      lane = {addr[1:0], 3'b000};
      if ((mop == MEM_LW || mop == MEM_SW) && addr[1:0] != 2'b00) begin
        push_expected((mop == MEM_LW) ? 2'd2 : 2'd3, '0, pc);
      end else if (mop == MEM_SW) begin
        shadow[idx] = rs2;
      end else if (mop == MEM_SB) begin
        shadow[idx][lane +: 8] = rs2[7:0];
      end else if (rd != '0) begin
        case (mop)
          MEM_LW:  push_expected(2'd1, rd, shadow[idx]);
          MEM_LBU: push_expected(2'd1, rd, {24'h0, shadow[idx][lane +: 8]});
          default: push_expected(2'd0, rd, '0);
        endcase
      end
    end
    step();
    valid_i = 1'b0;
    flush_i = 1'b0;
    pc = pc + 4;
  endtask

  task automatic mem_access(input mem_op_e mop, input xlen_t addr, input xlen_t data,
                            input reg_idx_t rd, input logic may_kill);
    xlen_t base;
    base = $urandom;
    send(ALU_ADD, mop, base, data, addr - base, 1'b1, rd, may_kill);
  endtask

  initial begin
    xlen_t       addr;
    int unsigned waited;
    void'($urandom(61376));
    err_cnt     = 0;
    checked     = 0;
    pc          = 32'h0000_0100;
    reset_i     = 1'b1;
    stall_i     = 1'b0;
    flush_i     = 1'b0;
    valid_i     = 1'b1; // Live instruction under reset must not leak
    inst_addr_i = '0;
    inst_data_i = INST_NOP;
    rs1_data_i  = '0;
    rs2_data_i  = '0;
    imm_data_i  = '0;
    use_imm_i   = 1'b0;
    rd_idx_i    = reg_idx_t'(1);
    alu_op_i    = ALU_ADD;
    mem_op_i    = MEM_NONE;
    repeat (3) @(posedge clk);
    #1;
    reset_i = 1'b0;
    valid_i = 1'b0;

    for (int i = 0; i < DMEM_WORDS; i++) begin // Memory is not reset
      mem_access(MEM_SW, xlen_t'(i * 4), $urandom, reg_idx_t'($urandom), 1'b0);
    end

    repeat (60) begin
      send(alu_op_e'(4'($urandom_range(7))), MEM_NONE, $urandom, $urandom, $urandom,
           1'($urandom), reg_idx_t'($urandom), 1'b1);
    end

    repeat (60) begin
      addr = xlen_t'($urandom_range(DMEM_WORDS - 1)) << 2;
      if ($urandom_range(1) == 0) begin
        mem_access(MEM_SW, addr, $urandom, reg_idx_t'($urandom), 1'b1);
        mem_access(MEM_LW, addr, '0, reg_idx_t'($urandom_range(31, 1)), 1'b1);
      end else begin
        mem_access(MEM_SB, addr | xlen_t'($urandom_range(3)), $urandom,
                   reg_idx_t'($urandom), 1'b1);
        mem_access(MEM_LBU, addr | xlen_t'($urandom_range(3)), '0,
                   reg_idx_t'($urandom_range(31, 1)), 1'b1);
      end
    end

    repeat (12) begin
      addr = (xlen_t'($urandom_range(DMEM_WORDS - 1)) << 2) | xlen_t'($urandom_range(3, 1));
      if ($urandom_range(1) == 0) begin
        mem_access(MEM_LW, addr, '0, reg_idx_t'($urandom_range(31, 1)), 1'b0);
      end else begin
        mem_access(MEM_SW, addr, $urandom, reg_idx_t'($urandom), 1'b0);
      end
      mem_access(MEM_LW, {addr[31:2], 2'b00}, '0, reg_idx_t'($urandom_range(31, 1)), 1'b0);
    end

    waited = 0;
    while (exp_kind.size() != 0 && waited < TIMEOUT_CYCLES) begin
      step();
      waited++;
    end
    if (exp_kind.size() != 0) begin
      $display("Timeout: %0d expected write-back or trap results never arrived",
               exp_kind.size());
      err_cnt++;
    end
    repeat (4) step(); // Catch stray results

    $display("Checked %0d results: %0d scoreboard errors, %0d assertion errors",
             checked, err_cnt, u_ex_mem_sub.u_assert.fail_cnt);
    if (err_cnt == 0 && u_ex_mem_sub.u_assert.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ex_mem_sub.f
logic/rv_pkg.sv
logic/pipe_reg.sv
logic/alu_exec.sv
logic/ex_mem.sv
logic/data_mem_stage.sv
logic/ex_mem_sub.sv
tests/ex_mem_sub_assert.sv
tests/tb_ex_mem_sub.sv

//--- Makefile
# Verilator simulation of ex_mem_sub
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_ex_mem_sub \
	  -f ex_mem_sub.f --Mdir obj_dir -o sim_ex_mem_sub
	./obj_dir/sim_ex_mem_sub +verilator+error+limit+1000 | tee sim.log
	@grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
